//--- sim/game_vectors.txt
# key(hex) hold(cycles) probe_x probe_y colour(hex, red green blue) led(hex)
# the first hold of 6 puts every later key change between two strobes
# idle after reset
0 6 40 50 1 00
0 14 40 4 7 00
0 14 10 10 0 00
0 14 100 10 0 00
0 14 40 70 0 00
# first round, target falls
4 14 38 2 7 00
0 46 39 3 7 00
0 14 39 3 0 00
# paddle to the left wall, then both keys
2 46 18 50 1 00
2 14 15 50 0 00
2 158 0 52 1 00
3 30 31 50 1 00
3 14 32 50 0 00
# bounce at the right wall and catch
1 254 71 37 7 00
1 14 70 38 7 00
1 14 77 39 0 00
1 14 69 50 1 00
1 14 5 5 2 01
0 14 70 44 7 01
0 14 45 52 1 01
# second round, paddle to the right wall, then away for a miss
1 14 24 48 1 01
1 190 79 55 1 01
1 62 47 50 0 01
2 382 0 48 1 01
0 142 5 5 4 01
0 14 62 52 7 01
0 14 10 52 1 01
0 14 90 20 0 01
# third round starts from the miss state
8 14 5 5 0 01
0 14 44 1 7 01

//--- build.f
verilog/game_pkg.sv
verilog/update_strobe.sv
verilog/player_motion.sv
verilog/target_motion.sv
verilog/game_fsm.sv
verilog/pixel_render.sv
verilog/lab_top.sv
sim/tb_lab_top.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing -Wno-fatal --top-module tb_lab_top -Mdir obj_dir -f build.f
	./obj_dir/Vtb_lab_top | tee sim.log
	grep -q "^Everything OK$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_lab_top.sv
`timescale 1ns/1ps

module tb_lab_top;

    // narrow screen so the target meets a side wall within one round
    localparam int screen_w   = 80;
    localparam int screen_h   = 64;
    localparam int strobe_len = 16;
    localparam int max_vec    = 64;

    logic                       clk = 1'b0;
    logic                       rst_n;
    logic [3:0]                 key;
    logic [game_pkg::w_x - 1:0] x;
    logic [game_pkg::w_y - 1:0] y;
    logic [7:0]                 led;
    logic [3:0]                 red;
    logic [3:0]                 green;
    logic [3:0]                 blue;
    logic                       display_on;

    lab_top #(
        .screen_width  ( screen_w ),
        .screen_height ( screen_h ),
        .strobe_width  ( 4        )
    ) u_dut (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .key        ( key        ),
        .led        ( led        ),
        .x          ( x          ),
        .y          ( y          ),
        .red        ( red        ),
        .green      ( green      ),
        .blue       ( blue       ),
        .display_on ( display_on )
    );

    always #4 clk = ~clk;

    int v_key  [max_vec];
    int v_hold [max_vec];
    int v_x    [max_vec];
    int v_y    [max_vec];
    int v_col  [max_vec];
    int v_led  [max_vec];
    int v_line [max_vec];
    int n_vec;
    int err_dut;
    int err_vec;
    int watchdog_ns = 0;

    // ------------------------------
    // reference game model
    // ------------------------------

    int                    cyc;
    logic [3:0]            key_m;
    int                    mp_x;
    int                    mp_y;
    int                    mt_x;
    int                    mt_y;
    logic                  mt_right;
    game_pkg::game_state_t m_state;
    int                    m_hits;
    logic                  restart_pending;

    task automatic home_sprites();
        mp_x     = screen_w / 2 - 16;
        mp_y     = screen_h - 16;
        mt_x     = screen_w / 2 - 4;
        mt_y     = 0;
        mt_right = 1'b1;
    endtask

    // advance the model by one clock edge
    task automatic step_model();
        int ph;
        ph = cyc % strobe_len;
        if (restart_pending) begin
            home_sprites();
            restart_pending = 1'b0;
        end
        if (cyc >= strobe_len) begin
            case (ph)
                1: begin
                    if (key_m[1] && !key_m[0]) begin
                        if (mp_x < game_pkg::player_step)
                            mp_x = 0;
                        else
                            mp_x = mp_x - game_pkg::player_step;
                    end
                    else if (key_m[0] && !key_m[1]) begin
                        if (mp_x + game_pkg::player_step > screen_w - game_pkg::player_w)
                            mp_x = screen_w - game_pkg::player_w;
                        else
                            mp_x = mp_x + game_pkg::player_step;
                    end
                end
                2: begin
                    if (m_state == game_pkg::st_run) begin
                        mt_x = mt_right ? mt_x + 1 : mt_x - 1;
                        mt_y = mt_y + 1;
                        if (mt_x == 0 || mt_x == screen_w - game_pkg::target_size)
                            mt_right = !mt_right;
                    end
                end
                3: begin
                    if (m_state == game_pkg::st_run) begin
                        if (mt_x < mp_x + game_pkg::player_w
                                && mp_x < mt_x + game_pkg::target_size
                                && mt_y < mp_y + game_pkg::player_h
                                && mp_y < mt_y + game_pkg::target_size) begin
                            m_state = game_pkg::st_hit;
                            if (m_hits < 255)
                                m_hits = m_hits + 1;
                        end
                        else if (mt_y + game_pkg::target_size > screen_h - 8) begin
                            m_state = game_pkg::st_miss;
                        end
                    end
                    else if (key_m != 4'd0) begin
                        m_state         = game_pkg::st_run;
                        restart_pending = 1'b1;
                    end
                end
                default: ;
            endcase
        end
    endtask

    function automatic game_pkg::colour_t expected_colour(int px, int py);
        if (px >= screen_w || py >= screen_h)
            return game_pkg::c_black;
        if (px >= mt_x && px < mt_x + game_pkg::target_size
                && py >= mt_y && py < mt_y + game_pkg::target_size)
            return game_pkg::c_white;
        if (px >= mp_x && px < mp_x + game_pkg::player_w
                && py >= mp_y && py < mp_y + game_pkg::player_h)
            return game_pkg::c_blue;
        case (m_state)
            game_pkg::st_hit:  return game_pkg::c_green;
            game_pkg::st_miss: return game_pkg::c_red;
            default:           return game_pkg::c_black;
        endcase
    endfunction

    // ------------------------------
    // checks and stimulus
    // ------------------------------

    // act_rgb holds red, green and blue, four bits each
    task automatic check_colour(game_pkg::colour_t exp_c, logic [11:0] act_rgb,
                                logic exp_on, logic act_on);
        game_pkg::colour_t act_c;
        logic [11:0]       exp_rgb;
        act_c   = game_pkg::colour_t'({act_rgb[11], act_rgb[7], act_rgb[3]});
        exp_rgb = {{4{exp_c[2]}}, {4{exp_c[1]}}, {4{exp_c[0]}}};
        if (act_c !== exp_c) begin
            $display("** Error pixel: expected 0x%h, got 0x%h at %0t", exp_c, act_c, $time);
            err_dut++;
        end
        else if (act_rgb !== exp_rgb) begin
            $display("** Error red/green/blue: expected 0x%h, got 0x%h at %0t",
                     exp_rgb, act_rgb, $time);
            err_dut++;
        end
        if (act_on !== exp_on) begin
            $display("** Error display_on: expected 0x%h, got 0x%h at %0t",
                     exp_on, act_on, $time);
            err_dut++;
        end
    endtask

    task automatic check_led(logic [7:0] exp_l, logic [7:0] act_l);
        if (act_l !== exp_l) begin
            $display("** Error led: expected 0x%02h, got 0x%02h at %0t", exp_l, act_l, $time);
            err_dut++;
        end
    endtask

    task automatic next_edge();
        @(posedge clk);
        cyc = cyc + 1;
        step_model();
    endtask

    task automatic read_vectors();
        int    fd;
        int    line_no;
        int    got;
        int    hold_sum;
        int    f_key;
        int    f_hold;
        int    f_x;
        int    f_y;
        int    f_col;
        int    f_led;
        string line;
        hold_sum = 0;
        line_no  = 0;
        fd = $fopen("sim/game_vectors.txt", "r");
        if (fd == 0) begin
            $display("cannot open the vector file sim/game_vectors.txt");
            err_vec++;
        end
        else begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                if (line.len() > 1 && line.getc(0) != "#") begin
                    got = $sscanf(line, "%h %d %d %d %h %h",
                                  f_key, f_hold, f_x, f_y, f_col, f_led);
                    if (got != 6 || f_hold < 0) begin
                        $display("vector line %0d is malformed", line_no);
                        err_vec++;
                    end
                    else if (n_vec >= max_vec) begin
                        $display("too many vectors, line %0d ignored", line_no);
                        err_vec++;
                    end
                    else begin
                        v_key[n_vec]  = f_key;
                        v_hold[n_vec] = f_hold;
                        v_x[n_vec]    = f_x;
                        v_y[n_vec]    = f_y;
                        v_col[n_vec]  = f_col;
                        v_led[n_vec]  = f_led;
                        v_line[n_vec] = line_no;
                        hold_sum      = hold_sum + f_hold;
                        n_vec++;
                    end
                end
            end
            $fclose(fd);
        end
        if (n_vec == 0) begin
            $display("no vectors were read");
            err_vec++;
        end
        watchdog_ns = (hold_sum + 1000) * 8;
    endtask

    // hold a key level, then probe one pixel
    task automatic apply_vector(int i);
        game_pkg::colour_t model_c;
        game_pkg::colour_t file_c;
        logic              exp_on;
        next_edge();
        key   <= 4'(v_key[i]);
        key_m  = 4'(v_key[i]);
        repeat (v_hold[i]) next_edge();
        model_c = expected_colour(v_x[i], v_y[i]);
        exp_on  = (v_x[i] < screen_w) && (v_y[i] < screen_h);
        x <= game_pkg::pos_x_t'(v_x[i]);
        y <= game_pkg::pos_y_t'(v_y[i]);
        next_edge();
        @(negedge clk);
        file_c = game_pkg::colour_t'(3'(v_col[i]));
        if (file_c !== model_c) begin
            $display("** Error vector line %0d colour: file 0x%h, model 0x%h",
                     v_line[i], file_c, model_c);
            err_vec++;
        end
        if (8'(v_led[i]) !== 8'(m_hits)) begin
            $display("** Error vector line %0d led: file 0x%02h, model 0x%02h",
                     v_line[i], 8'(v_led[i]), 8'(m_hits));
            err_vec++;
        end
        check_colour(file_c, {red, green, blue}, exp_on, display_on);
        check_led(8'(v_led[i]), led);
    endtask

    initial begin
        int i;
        rst_n           = 1'b0;
        key             = 4'd0;
        x               = '0;
        y               = '0;
        n_vec           = 0;
        err_dut         = 0;
        err_vec         = 0;
        cyc             = 0;
        key_m           = 4'd0;
        m_state         = game_pkg::st_idle;
        m_hits          = 0;
        restart_pending = 1'b0;
        home_sprites();
        read_vectors();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        for (i = 0; i < n_vec; i++)
            apply_vector(i);
        $display("errors: dut %0d, vectors %0d", err_dut, err_vec);
        if (err_dut == 0 && err_vec == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

    // run time bound from the hold cycles in the vectors
    initial begin
        wait (watchdog_ns > 0);
        #(watchdog_ns);
        $display("watchdog expired after %0d ns, the run did not finish", watchdog_ns);
        $display("Something failed");
        $finish;
    end

endmodule

//--- verilog/lab_top.sv
`timescale 1ns/1ps

module lab_top
#(
    parameter int clk_mhz       = 50,
    parameter int screen_width  = 640,
    parameter int screen_height = 480,
    parameter int strobe_width  = $clog2(clk_mhz * 1000 * 1000) - 6
)
(
    input                              clk,
    input                              rst_n,

    // keys and leds
    input        [3:0]                 key,
    output logic [7:0]                 led,

    // graphics
    input        [game_pkg::w_x - 1:0] x,
    input        [game_pkg::w_y - 1:0] y,

    output logic [3:0]                 red,
    output logic [3:0]                 green,
    output logic [3:0]                 blue,
    output logic                       display_on
);

    // ------------------------------
    // key mapping
    // ------------------------------

    logic left;
    logic right;
    logic launch;

    assign left   = key[1];
    assign right  = key[0];
    // any key starts a round
    assign launch = |key;

    // ------------------------------
    // pipeline stages
    // ------------------------------

    logic tick;
    logic tick_p;
    logic tick_t;
    logic restart;
    logic freeze;

    game_pkg::sprite_t     player;
    game_pkg::sprite_t     target;
    game_pkg::game_state_t state;
    game_pkg::colour_t     pixel;
    logic [7:0]            hits;

    update_strobe #(
        .strobe_width ( strobe_width )
    ) i_update_strobe (
        .clk   ( clk   ),
        .rst_n ( rst_n ),
        .tick  ( tick  )
    );

    player_motion #(
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height )
    ) i_player_motion (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .tick    ( tick    ),
        .left    ( left    ),
        .right   ( right   ),
        .restart ( restart ),
        .player  ( player  ),
        .tick_p  ( tick_p  )
    );

    target_motion #(
        .screen_width ( screen_width )
    ) i_target_motion (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .tick_p  ( tick_p  ),
        .restart ( restart ),
        .freeze  ( freeze  ),
        .target  ( target  ),
        .tick_t  ( tick_t  )
    );

    game_fsm #(
        .screen_height ( screen_height )
    ) i_game_fsm (
        .clk     ( clk     ),
        .rst_n   ( rst_n   ),
        .tick_t  ( tick_t  ),
        .launch  ( launch  ),
        .player  ( player  ),
        .target  ( target  ),
        .state   ( state   ),
        .restart ( restart ),
        .freeze  ( freeze  ),
        .hits    ( hits    )
    );

    pixel_render #(
        .screen_width  ( screen_width  ),
        .screen_height ( screen_height )
    ) i_pixel_render (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .x          ( x          ),
        .y          ( y          ),
        .player     ( player     ),
        .target     ( target     ),
        .state      ( state      ),
        .pixel      ( pixel      ),
        .display_on ( display_on )
    );

    // ------------------------------
    // outputs
    // ------------------------------

    logic [2:0] rgb;

    assign led = hits;
    assign rgb = pixel;

    // one colour bit drives the whole channel
    assign red   = {4{rgb[2]}};
    assign green = {4{rgb[1]}};
    assign blue  = {4{rgb[0]}};

endmodule

//--- verilog/pixel_render.sv
`timescale 1ns/1ps

module pixel_render
#(
    parameter int screen_width  = 640,
    parameter int screen_height = 480
)
(
    input                              clk,
    input                              rst_n,
    input        [game_pkg::w_x - 1:0] x,
    input        [game_pkg::w_y - 1:0] y,
    input  game_pkg::sprite_t          player,
    input  game_pkg::sprite_t          target,
    input  game_pkg::game_state_t      state,
    output game_pkg::colour_t          pixel,
    output logic                       display_on
);

    localparam game_pkg::ext_x_t x_limit = game_pkg::ext_x_t'(screen_width);
    localparam game_pkg::ext_y_t y_limit = game_pkg::ext_y_t'(screen_height);

    // ------------------------------
    // hit tests for this pixel
    // ------------------------------

    game_pkg::ext_x_t target_right;
    game_pkg::ext_y_t target_bottom;
    game_pkg::ext_x_t player_right;
    game_pkg::ext_y_t player_bottom;

    logic on_screen;
    logic in_target;
    logic in_player;

    assign target_right  = {1'b0, target.x} + game_pkg::ext_x_t'(game_pkg::target_size);
    assign target_bottom = {1'b0, target.y} + game_pkg::ext_y_t'(game_pkg::target_size);
    assign player_right  = {1'b0, player.x} + game_pkg::ext_x_t'(game_pkg::player_w);
    assign player_bottom = {1'b0, player.y} + game_pkg::ext_y_t'(game_pkg::player_h);

    assign on_screen = ({1'b0, x} < x_limit) && ({1'b0, y} < y_limit);

    assign in_target = (x >= target.x) && ({1'b0, x} < target_right)
                    && (y >= target.y) && ({1'b0, y} < target_bottom);

    assign in_player = (x >= player.x) && ({1'b0, x} < player_right)
                    && (y >= player.y) && ({1'b0, y} < player_bottom);

    game_pkg::colour_t background;
    game_pkg::colour_t colour_next;

    // background shows how the last round ended
    always_comb begin
        case (state)
            game_pkg::st_hit:  background = game_pkg::c_green;
            game_pkg::st_miss: background = game_pkg::c_red;
            default:           background = game_pkg::c_black;
        endcase
    end

    always_comb begin
        if (!on_screen)
            colour_next = game_pkg::c_black;
        else if (in_target)
            colour_next = game_pkg::c_white;
        else if (in_player)
            colour_next = game_pkg::c_blue;
        else
            colour_next = background;
    end

    // one cycle from x and y to colour
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pixel      <= game_pkg::c_black;
            display_on <= 1'b0;
        end
        else begin
            pixel      <= colour_next;
            display_on <= on_screen;
        end
    end

endmodule

//--- verilog/game_fsm.sv
`timescale 1ns/1ps

module game_fsm
#(
    parameter int screen_height = 480
)
(
    input                         clk,
    input                         rst_n,
    input                         tick_t,
    input                         launch,
    input  game_pkg::sprite_t     player,
    input  game_pkg::sprite_t     target,
    output game_pkg::game_state_t state,
    output logic                  restart,
    output logic                  freeze,
    output logic [7:0]            hits
);

    // target bottom beyond this row has passed the paddle
    localparam game_pkg::ext_y_t miss_row =
        game_pkg::ext_y_t'(screen_height - 8);

    // ------------------------------
    // collision check
    // ------------------------------

    game_pkg::ext_x_t player_right;
    game_pkg::ext_x_t target_right;
    game_pkg::ext_y_t player_bottom;
    game_pkg::ext_y_t target_bottom;

    logic overlap;
    logic missed;

    assign player_right  = {1'b0, player.x} + game_pkg::ext_x_t'(game_pkg::player_w);
    assign target_right  = {1'b0, target.x} + game_pkg::ext_x_t'(game_pkg::target_size);
    assign player_bottom = {1'b0, player.y} + game_pkg::ext_y_t'(game_pkg::player_h);
    assign target_bottom = {1'b0, target.y} + game_pkg::ext_y_t'(game_pkg::target_size);

    // rectangles intersect on both axes
    assign overlap = ({1'b0, target.x} < player_right)
                  && ({1'b0, player.x} < target_right)
                  && ({1'b0, target.y} < player_bottom)
                  && ({1'b0, player.y} < target_bottom);

    assign missed = (target_bottom > miss_row);

    // ------------------------------
    // round FSM
    // ------------------------------

    game_pkg::game_state_t state_next;
    logic                  start_round;
    logic                  score;

    always_comb begin
        state_next  = state;
        start_round = 1'b0;
        score       = 1'b0;
        if (tick_t) begin
            case (state)
                game_pkg::st_run: begin
                    // a catch wins over a miss on the same strobe
                    if (overlap) begin
                        state_next = game_pkg::st_hit;
                        score      = 1'b1;
                    end
                    else if (missed) begin
                        state_next = game_pkg::st_miss;
                    end
                end
                default: begin
                    // idle, hit or miss wait for a key
                    if (launch) begin
                        state_next  = game_pkg::st_run;
                        start_round = 1'b1;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= game_pkg::st_idle;
            restart <= 1'b0;
            hits    <= 8'd0;
        end
        else begin
            state   <= state_next;
            restart <= start_round;
            // saturate at 255
            if (score && hits != 8'hff)
                hits <= hits + 8'd1;
        end
    end

    // sprites only move while a round runs
    assign freeze = (state != game_pkg::st_run);

endmodule

//--- verilog/target_motion.sv
`timescale 1ns/1ps

module target_motion
#(
    parameter int screen_width = 640
)
(
    input                     clk,
    input                     rst_n,
    input                     tick_p,
    input                     restart,
    input                     freeze,
    output game_pkg::sprite_t target,
    output logic              tick_t
);

    // ------------------------------
    // geometry
    // ------------------------------

    // centred on the top row
    localparam game_pkg::pos_x_t start_x =
        game_pkg::pos_x_t'(screen_width / 2 - 4);

    localparam game_pkg::sprite_t home = '{x: start_x, y: '0};

    // right wall for the target corner
    localparam game_pkg::pos_x_t max_x =
        game_pkg::pos_x_t'(screen_width - game_pkg::target_size);

    // horizontal direction, 1 means moving right
    logic dir_right;

    game_pkg::pos_x_t next_x;
    logic             at_wall;

    always_comb begin
        if (dir_right)
            next_x = target.x + 1'b1;
        else
            next_x = target.x - 1'b1;
    end

    // flip on the same strobe that reaches a wall
    assign at_wall = (next_x == '0) || (next_x == max_x);

    // ------------------------------
    // position registers
    // ------------------------------

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            target    <= home;
            dir_right <= 1'b1;
            tick_t    <= 1'b0;
        end
        else begin
            tick_t <= tick_p;
            if (restart) begin
                target    <= home;
                dir_right <= 1'b1;
            end
            else if (tick_p && !freeze) begin
                target.x <= next_x;
                // one row down per strobe
                target.y <= target.y + 1'b1;
                if (at_wall)
                    dir_right <= !dir_right;
            end
        end
    end

endmodule

//--- verilog/player_motion.sv
`timescale 1ns/1ps

module player_motion
#(
    parameter int screen_width  = 640,
    parameter int screen_height = 480
)
(
    input                     clk,
    input                     rst_n,
    input                     tick,
    input                     left,
    input                     right,
    input                     restart,
    output game_pkg::sprite_t player,
    output logic              tick_p
);

    // ------------------------------
    // geometry
    // ------------------------------

    // centred, two paddle heights above the bottom edge
    localparam game_pkg::pos_x_t start_x =
        game_pkg::pos_x_t'(screen_width / 2 - 16);
    localparam game_pkg::pos_y_t start_y =
        game_pkg::pos_y_t'(screen_height - 16);

    localparam game_pkg::sprite_t home = '{x: start_x, y: start_y};

    // rightmost legal corner
    localparam game_pkg::ext_x_t max_x =
        game_pkg::ext_x_t'(screen_width - game_pkg::player_w);

    localparam game_pkg::ext_x_t step =
        game_pkg::ext_x_t'(game_pkg::player_step);

    // ------------------------------
    // next position
    // ------------------------------

    game_pkg::ext_x_t moved_right;
    game_pkg::pos_x_t next_x;

    assign moved_right = {1'b0, player.x} + step;

    always_comb begin
        next_x = player.x;
        if (left && !right) begin
            // stop at the left wall
            if ({1'b0, player.x} < step)
                next_x = '0;
            else
                next_x = player.x - game_pkg::pos_x_t'(game_pkg::player_step);
        end
        else if (right && !left) begin
            if (moved_right > max_x)
                next_x = game_pkg::pos_x_t'(max_x);
            else
                next_x = game_pkg::pos_x_t'(moved_right);
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            player <= home;
            tick_p <= 1'b0;
        end
        else begin
            // strobe follows the data one stage down
            tick_p <= tick;
            if (restart)
                player <= home;
            else if (tick)
                player.x <= next_x;
        end
    end

endmodule

//--- verilog/update_strobe.sv
`timescale 1ns/1ps

module update_strobe
#(
    parameter int strobe_width = 20
)
(
    input        clk,
    input        rst_n,
    output logic tick
);

    // free-running period counter
    logic [strobe_width - 1:0] cnt;

    // tick is registered on the same edge where the counter wraps to zero,
    // so the first pulse lands a full period after reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cnt  <= '0;
            tick <= 1'b0;
        end
        else begin
            cnt  <= cnt + 1'b1;
            tick <= (cnt == '1);
        end
    end

endmodule

//--- verilog/game_pkg.sv
package game_pkg;

    // coordinate widths, enough for 640 x 480
    localparam int w_x = 10;
    localparam int w_y = 9;

    typedef logic [w_x - 1:0] pos_x_t;
    typedef logic [w_y - 1:0] pos_y_t;

    // one spare bit so that edge sums never wrap
    typedef logic [w_x:0] ext_x_t;
    typedef logic [w_y:0] ext_y_t;

    // top-left corner of a sprite
    typedef struct packed {
        pos_x_t x;
        pos_y_t y;
    } sprite_t;

    // ------------------------------
    // sprite geometry, in pixels
    // ------------------------------

    localparam int player_w    = 32;
    localparam int player_h    = 8;
    localparam int target_size = 8;
    localparam int player_step = 2;

    // bit 2 red, bit 1 green, bit 0 blue
    typedef enum logic [2:0] {
        c_black = 3'b000,
        c_blue  = 3'b001,
        c_green = 3'b010,
        c_red   = 3'b100,
        c_white = 3'b111
    } colour_t;

    typedef enum logic [1:0] {
        st_idle = 2'd0,
        st_run  = 2'd1,
        st_hit  = 2'd2,
        st_miss = 2'd3
    } game_state_t;

endpackage
